/* linkPkg.sv */
`default_nettype none

package linkPkg;

  localparam int BeatWidth = 32;       // width of every beat on both streams
  localparam int WordCountWidth = 16;  // word count field of a header beat
  localparam int MaxWordsLimit = 16;   // no build collects more payload words than this

  // the portal field fills the header beat next to the word count
  typedef struct packed {
    logic [BeatWidth-WordCountWidth-1:0]      portal;
    logic [WordCountWidth-1:0]                wordCount;
    logic [MaxWordsLimit-1:0][BeatWidth-1:0]  payload;  // word 0 arrives first
  } requestMsgT;

endpackage

`default_nettype wire

/* portalPkg.sv */
`default_nettype none

package portalPkg;

  import linkPkg::*;

  localparam int PortalWidth = BeatWidth - WordCountWidth;  // lower half of a header beat
  localparam int ResponseWords = 2;                         // sum word, then XOR word

  // header beat, word count in the upper half and portal number in the lower half
  typedef struct packed {
    logic [WordCountWidth-1:0] wordCount;
    logic [PortalWidth-1:0]    portal;
  } portalHeaderT;

  typedef struct packed {
    logic [PortalWidth-1:0] portal;
    logic [BeatWidth-1:0]   sum;      // 32-bit wrapping sum of the request payload
    logic [BeatWidth-1:0]   xorWord;  // XOR of the request payload
  } responseMsgT;

endpackage

`default_nettype wire

/* beatIf.sv */
`default_nettype none

interface beatIf
  import linkPkg::*;
();

  logic                 valid;
  logic                 ready;
  logic [BeatWidth-1:0] data;
  logic                 last;   // final beat of a message

  modport sender (
    output valid,
    output data,
    output last,
    input  ready
  );

  modport receiver (
    input  valid,
    input  data,
    input  last,
    output ready
  );

endinterface

`default_nettype wire

/* beatDeserializer.sv */
`default_nettype none

module beatDeserializer
  import linkPkg::*;
  import portalPkg::*;
#(
  parameter int MaxWords = 8
) (
  input  logic       CLK,
  input  logic       reset,
  beatIf.receiver    beats,
  output requestMsgT msg,
  output logic       msgValid,
  input  logic       msgReady
);

  localparam int PayIdxWidth = $clog2(MaxWordsLimit);

  typedef enum logic [1:0] {
    WaitStart,
    ExpectHeader,
    CollectPayload,
    HoldMsg
  } stateT;

  stateT                     state;
  logic [WordCountWidth-1:0] wordIdx;  // next payload slot to fill
  portalHeaderT              hdr;
  logic                      beatFire;

  assign hdr = portalHeaderT'(beats.data);
  assign beats.ready = (state == ExpectHeader) || (state == CollectPayload);
  assign beatFire = beats.valid && beats.ready;
  assign msgValid = (state == HoldMsg);  // nothing is accepted while the message waits

  always_ff @(posedge CLK) begin
    if (reset) begin
      state <= WaitStart;
    end else begin
      unique case (state)
        WaitStart: begin
          state <= ExpectHeader;  // one quiet cycle so ready comes up after reset
        end
        ExpectHeader: begin
          if (beatFire) begin
            state <= CollectPayload;
          end
        end
        CollectPayload: begin
          if (beatFire && beats.last) begin
            state <= HoldMsg;
          end
        end
        default: begin
          if (msgReady) begin
            state <= ExpectHeader;
          end
        end
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (beatFire) begin
      if (state == ExpectHeader) begin
        msg.portal <= hdr.portal;
        msg.wordCount <= hdr.wordCount;
        wordIdx <= '0;
      end else begin
        msg.payload[wordIdx[PayIdxWidth-1:0]] <= beats.data;  // words past the count keep old data
        wordIdx <= wordIdx + 1'b1;
      end
    end
  end

  // the sender's last flag has to agree with the count it put in the header
  assert property (@(posedge CLK) disable iff (reset)
    beatFire |-> beats.last == ((state == CollectPayload) && (wordIdx == msg.wordCount - 1'b1)));

  assert property (@(posedge CLK) disable iff (reset)
    beatFire && (state == ExpectHeader) |-> hdr.wordCount >= 1 && hdr.wordCount <= MaxWords);

endmodule

`default_nettype wire

/* msgFifo.sv */
`default_nettype none

module msgFifo #(
  parameter int  FifoDepth = 4,
  parameter type payloadT = logic
) (
  input  logic    CLK,
  input  logic    reset,
  input  payloadT inData,
  input  logic    inValid,
  output logic    inReady,
  output payloadT outData,
  output logic    outValid,
  input  logic    outReady
);

  localparam int PtrWidth = $clog2(FifoDepth);

  payloadT             mem [FifoDepth];
  logic [PtrWidth-1:0] wrPtr;   // pointers wrap on their own since the depth is a power of two
  logic [PtrWidth-1:0] rdPtr;
  logic [PtrWidth:0]   count;
  logic                push;
  logic                pop;

  assign inReady = (count != (PtrWidth + 1)'(FifoDepth));
  assign outValid = (count != '0);
  assign outData = mem[rdPtr];
  assign push = inValid && inReady;
  assign pop = outValid && outReady;

  always_ff @(posedge CLK) begin
    if (reset) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (pop) begin
        rdPtr <= rdPtr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (push) begin
      mem[wrPtr] <= inData;  // read side sees it next cycle, no bypass
    end
  end

  assert property (@(posedge CLK) disable iff (reset)
    count <= (PtrWidth + 1)'(FifoDepth));

endmodule

`default_nettype wire

/* checksumResponder.sv */
`default_nettype none

module checksumResponder
  import linkPkg::*;
  import portalPkg::*;
#(
  parameter int RequestPortal = 3,
  parameter int IndicationPortal = 5
) (
  input  logic        CLK,
  input  logic        reset,
  input  requestMsgT  req,
  input  logic        reqValid,
  output logic        reqReady,
  output responseMsgT rsp,
  output logic        rspValid,
  input  logic        rspReady
);

  typedef enum logic [1:0] {
    Idle,
    Walk,
    Offer
  } stateT;

  stateT                                   state;
  logic [MaxWordsLimit-1:0][BeatWidth-1:0] payloadReg;  // current word always sits in slot 0
  logic [WordCountWidth-1:0]               wordsLeft;
  logic [BeatWidth-1:0]                    sumAcc;
  logic [BeatWidth-1:0]                    xorAcc;
  logic                                    forUs;

  assign reqReady = (state == Idle);
  assign forUs = (req.portal == PortalWidth'(RequestPortal));
  assign rspValid = (state == Offer);
  assign rsp.portal = PortalWidth'(IndicationPortal);
  assign rsp.sum = sumAcc;
  assign rsp.xorWord = xorAcc;

  always_ff @(posedge CLK) begin
    if (reset) begin
      state <= Idle;
    end else begin
      unique case (state)
        Idle: begin
          if (reqValid && forUs) begin
            state <= Walk;  // requests for other portals are popped and forgotten
          end
        end
        Walk: begin
          if (wordsLeft == 1) begin
            state <= Offer;
          end
        end
        default: begin
          if (rspReady) begin
            state <= Idle;
          end
        end
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (state == Idle) begin
      payloadReg <= req.payload;
      wordsLeft <= req.wordCount;
      sumAcc <= '0;
      xorAcc <= '0;
    end else if (state == Walk) begin
      sumAcc <= sumAcc + payloadReg[0];
      xorAcc <= xorAcc ^ payloadReg[0];
      payloadReg <= {BeatWidth'(0), payloadReg[MaxWordsLimit-1:1]};
      wordsLeft <= wordsLeft - 1'b1;
    end
  end

  assert property (@(posedge CLK) disable iff (reset)
    rspValid && !rspReady |=> rspValid && $stable(rsp));

endmodule

`default_nettype wire

/* beatSerializer.sv */
`default_nettype none

module beatSerializer
  import linkPkg::*;
  import portalPkg::*;
(
  input  logic        CLK,
  input  logic        reset,
  input  responseMsgT msg,
  input  logic        msgValid,
  output logic        msgReady,
  beatIf.sender       beats
);

  localparam logic [1:0] HeaderBeat = 2'd0;
  localparam logic [1:0] SumBeat = 2'd1;
  localparam logic [1:0] XorBeat = 2'd2;

  responseMsgT  rspReg;
  logic         busy;
  logic [1:0]   beatIdx;  // which of the three beats is on the bus
  portalHeaderT hdr;
  logic         beatFire;

  assign msgReady = !busy;
  assign beats.valid = busy;
  assign beats.last = (beatIdx == XorBeat);  // index rests at the header beat while idle
  assign beatFire = beats.valid && beats.ready;

  assign hdr.wordCount = WordCountWidth'(ResponseWords);
  assign hdr.portal = rspReg.portal;

  always_comb begin
    unique case (beatIdx)
      HeaderBeat: beats.data = hdr;
      SumBeat: beats.data = rspReg.sum;
      default: beats.data = rspReg.xorWord;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      busy <= 1'b0;
      beatIdx <= HeaderBeat;
    end else begin
      if (msgValid && msgReady) begin
        busy <= 1'b1;
        beatIdx <= HeaderBeat;
      end else if (beatFire) begin
        if (beats.last) begin
          busy <= 1'b0;
          beatIdx <= HeaderBeat;
        end else begin
          beatIdx <= beatIdx + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (msgValid && msgReady) begin
      rspReg <= msg;
    end
  end

  // a stalled beat must not change under the receiver
  assert property (@(posedge CLK) disable iff (reset)
    beats.valid && !beats.ready |=> beats.valid && $stable(beats.data) && $stable(beats.last));

endmodule

`default_nettype wire

/* portalLinkTop.sv */
`default_nettype none

module portalLinkTop
  import linkPkg::*;
  import portalPkg::*;
#(
  parameter int MaxWords = 8,
  parameter int FifoDepth = 4,
  parameter int RequestPortal = 3,
  parameter int IndicationPortal = 5
) (
  input  logic                 CLK,
  input  logic                 reset,
  input  logic                 inValid,
  input  logic [BeatWidth-1:0] inData,
  input  logic                 inLast,
  output logic                 inReady,
  output logic                 outValid,
  output logic [BeatWidth-1:0] outData,
  output logic                 outLast,
  input  logic                 outReady
);

  beatIf inBeats ();
  beatIf outBeats ();

  requestMsgT  reqIn;
  logic        reqInValid;
  logic        reqInReady;
  requestMsgT  reqOut;
  logic        reqOutValid;
  logic        reqOutReady;
  responseMsgT rspIn;
  logic        rspInValid;
  logic        rspInReady;
  responseMsgT rspOut;
  logic        rspOutValid;
  logic        rspOutReady;

  assign inBeats.valid = inValid;
  assign inBeats.data = inData;
  assign inBeats.last = inLast;
  assign inReady = inBeats.ready;

  assign outValid = outBeats.valid;
  assign outData = outBeats.data;
  assign outLast = outBeats.last;
  assign outBeats.ready = outReady;

  beatDeserializer #(.MaxWords(MaxWords)) u_beatDeserializer (
    .CLK(CLK), .reset(reset), .beats(inBeats),
    .msg(reqIn), .msgValid(reqInValid), .msgReady(reqInReady)
  );

  msgFifo #(.FifoDepth(FifoDepth), .payloadT(requestMsgT)) u_reqFifo (
    .CLK(CLK), .reset(reset),
    .inData(reqIn), .inValid(reqInValid), .inReady(reqInReady),
    .outData(reqOut), .outValid(reqOutValid), .outReady(reqOutReady)
  );

  checksumResponder #(
    .RequestPortal(RequestPortal),
    .IndicationPortal(IndicationPortal)
  ) u_checksumResponder (
    .CLK(CLK), .reset(reset),
    .req(reqOut), .reqValid(reqOutValid), .reqReady(reqOutReady),
    .rsp(rspIn), .rspValid(rspInValid), .rspReady(rspInReady)
  );

  msgFifo #(.FifoDepth(FifoDepth), .payloadT(responseMsgT)) u_rspFifo (
    .CLK(CLK), .reset(reset),
    .inData(rspIn), .inValid(rspInValid), .inReady(rspInReady),
    .outData(rspOut), .outValid(rspOutValid), .outReady(rspOutReady)
  );

  beatSerializer u_beatSerializer (
    .CLK(CLK), .reset(reset),
    .msg(rspOut), .msgValid(rspOutValid), .msgReady(rspOutReady),
    .beats(outBeats)
  );

endmodule

`default_nettype wire

/* tbPortalLink.sv */
`default_nettype none

module tbPortalLink
  import linkPkg::*;
  import portalPkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int MaxWords = 8;
  localparam int RequestPortal = 3;
  localparam int IndicationPortal = 5;
  localparam int NumRequests = 60;
  localparam int StallStart = 150;
  localparam int StallLen = 200;
  localparam int CycleLimit = NumRequests * (MaxWords + 4) * 4 + StallLen;

  logic                 CLK;
  logic                 reset;
  logic                 inValid;
  logic [BeatWidth-1:0] inData;
  logic                 inLast;
  logic                 inReady;
  logic                 outValid;
  logic [BeatWidth-1:0] outData;
  logic                 outLast;
  logic                 outReady;

  logic [31:0] stimState = 32'd5584;
  logic [31:0] readyState = 32'd5584 ^ 32'h9e3779b9;  // separate stream for back-pressure
  logic [63:0] expQ [$];   // {sum, xor} per request that expects a response
  logic [63:0] expNow;
  logic        haveExp = 1'b0;
  int          errorCount = 0;
  int          cycleCount = 0;
  int          inIdx = 0;
  int          outIdx = 0;
  int          requestsIn = 0;
  int          pushCount = 0;
  int          rspDone = 0;
  int          lowRun = 0;
  int          maxLowRun = 0;
  logic [15:0] inPortal;
  logic [31:0] inSum;
  logic [31:0] inXor;
  logic        prevStall = 1'b0;
  logic [31:0] prevData;
  logic        prevLast;
  portalHeaderT hdrIn;
  portalHeaderT hdrOut;

  portalLinkTop u_portalLinkTop (.*);

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic compareValue(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("ERROR %s expected 0x%08h actual 0x%08h at cycle %0d", name, exp, act, cycleCount);
      errorCount++;
    end
  endtask

  task automatic finishRun();
    $display("errors: %0d", errorCount);
    if (errorCount == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  endtask

  // called at 1 ns after a rising edge, returns at the same point after the beat is taken
  task automatic sendBeat(input logic [31:0] data, input logic last);
    logic taken;
    taken = 1'b0;
    inValid = 1'b1;
    inData = data;
    inLast = last;
    while (!taken) begin
      @(negedge CLK);
      taken = inReady;
      @(posedge CLK);
      #1;
    end
    inValid = 1'b0;
    inLast = 1'b0;
  endtask

  task automatic idleGap();
    stimState = xorshift(stimState);
    if (stimState[2:0] == 3'd0) begin
      repeat (int'(stimState[4:3]) + 1) begin
        @(posedge CLK);
        #1;
      end
    end
  endtask

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  initial begin
    outReady = 1'b0;
    forever begin
      @(posedge CLK);
      #1;
      readyState = xorshift(readyState);
      if (cycleCount >= StallStart && cycleCount < StallStart + StallLen) begin
        outReady = 1'b0;  // long stall so back-pressure reaches the input
      end else begin
        outReady = (readyState % 32'd10) < 32'd7;
      end
    end
  end

  initial begin
    wait (cycleCount >= CycleLimit);
    $display("timeout: the run did not finish within %0d cycles", CycleLimit);
    errorCount++;
    finishRun();
  end

  // all sampling happens on the falling edge where DUT outputs are settled
  always @(negedge CLK) begin
    if (!reset) begin
      cycleCount++;
      if (cycleCount == 1) begin
        compareValue("inReady", 32'd0, 32'(inReady));
      end
      if (requestsIn == 0) begin
        compareValue("outValid", 32'd0, 32'(outValid));  // nothing may leave before a request
      end
      if (cycleCount >= StallStart && cycleCount < StallStart + StallLen && !inReady) begin
        lowRun++;
        if (lowRun > maxLowRun) begin
          maxLowRun = lowRun;
        end
      end else begin
        lowRun = 0;
      end
      if (inValid && inReady) begin
        if (inIdx == 0) begin
          hdrIn = portalHeaderT'(inData);
          inPortal = hdrIn.portal;
          inSum = '0;
          inXor = '0;
        end else begin
          inSum = inSum + inData;
          inXor = inXor ^ inData;
        end
        if (inLast) begin
          if (inPortal == 16'(RequestPortal)) begin
            expQ.push_back({inSum, inXor});
            pushCount++;
          end
          requestsIn++;
          inIdx = 0;
        end else begin
          inIdx++;
        end
      end
      if (prevStall) begin
        compareValue("outValid", 32'd1, 32'(outValid));
        compareValue("outData", prevData, outData);
        compareValue("outLast", 32'(prevLast), 32'(outLast));
      end
      prevStall = outValid && !outReady;
      prevData = outData;
      prevLast = outLast;
      if (outValid && outReady) begin
        if (outIdx == 0) begin
          hdrOut = portalHeaderT'(outData);
          compareValue("outData.wordCount", 32'd2, 32'(hdrOut.wordCount));
          compareValue("outData.portal", 32'(IndicationPortal), 32'(hdrOut.portal));
          compareValue("outLast", 32'd0, 32'(outLast));
          if (expQ.size() == 0) begin
            $display("a response came out that no request was waiting for");
            errorCount++;
            haveExp = 1'b0;
          end else begin
            expNow = expQ.pop_front();
            haveExp = 1'b1;
          end
          outIdx = 1;
        end else if (outIdx == 1) begin
          if (haveExp) begin
            compareValue("outData.sum", expNow[63:32], outData);
          end
          compareValue("outLast", 32'd0, 32'(outLast));
          outIdx = 2;
        end else begin
          if (haveExp) begin
            compareValue("outData.xor", expNow[31:0], outData);
          end
          compareValue("outLast", 32'd1, 32'(outLast));
          rspDone++;
          outIdx = 0;
        end
      end
    end
  end

  initial begin
    int           len;
    logic [15:0]  portal;
    portalHeaderT hdr;
    reset = 1'b1;
    inValid = 1'b0;
    inData = '0;
    inLast = 1'b0;
    repeat (2) @(posedge CLK);
    #1;
    reset = 1'b0;
    @(posedge CLK);
    #1;
    for (int r = 0; r < NumRequests; r++) begin
      stimState = xorshift(stimState);
      if (r < MaxWords) begin
        len = r + 1;  // every length once, shortest first
        portal = 16'(RequestPortal);
      end else begin
        len = int'(stimState % 32'(MaxWords)) + 1;
        stimState = xorshift(stimState);
        if (stimState[1:0] != 2'd0) begin
          portal = 16'(RequestPortal);
        end else begin
          portal = stimState[23:8];
          if (portal == 16'(RequestPortal)) begin
            portal = 16'(RequestPortal + 1);
          end
        end
      end
      hdr.wordCount = 16'(len);
      hdr.portal = portal;
      sendBeat(32'(hdr), 1'b0);
      idleGap();
      for (int w = 0; w < len; w++) begin
        stimState = xorshift(stimState);
        sendBeat(stimState, w == len - 1);
        idleGap();
      end
    end
    while (rspDone < pushCount) begin
      @(posedge CLK);
    end
    repeat (50) @(posedge CLK);  // room for a stray response to show up
    if (expQ.size() != 0) begin
      $display("%0d expected responses never came out", expQ.size());
      errorCount++;
    end
    if (maxLowRun < 40) begin
      $display("inReady did not stay low during the long output stall");
      errorCount++;
    end
    finishRun();
  end

endmodule

`default_nettype wire

/* list.f */
linkPkg.sv
portalPkg.sv
beatIf.sv
beatDeserializer.sv
msgFifo.sv
checksumResponder.sv
beatSerializer.sv
portalLinkTop.sv
tbPortalLink.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tbPortalLink \
  -Mdir obj_dir -o simPortalLink
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

output=$(./obj_dir/simPortalLink)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Everything OK"; then
  exit 0
fi
exit 1
